/* i2c_burst_slave.f */
hw/i2c_bus_pkg.sv
hw/burst_mem_pkg.sv
hw/i2c_line_sampler.sv
hw/i2c_deserializer.sv
hw/burst_write_queue.sv
hw/i2c_burst_slave_top.sv
tb/tb_clock_gen.sv
tb/tb_i2c_burst_slave.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the I2C burst slave testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing \
	-f i2c_burst_slave.f \
	--top-module tb_i2c_burst_slave \
	-o sim_bin \
	&& ./obj_dir/sim_bin > sim.log 2>&1 \
	&& grep -q "Everything OK" sim.log \
	&& { echo "PASS"; exit 0; } \
	|| { echo "FAIL"; exit 1; }

/* tb/tb_i2c_burst_slave.sv */
`timescale 1ns/1ps

module tb_i2c_burst_slave;

	localparam logic [i2c_bus_pkg::STRAP_BITS-1:0] STRAP_VALUE = 3'b101;
	localparam int HALF_CLKS = 12;
	localparam int ACCEPT_LIMIT = burst_mem_pkg::MEM_CREDITS + burst_mem_pkg::QUEUE_DEPTH;

	// bytes on the bus over all tests, 9 bits of 2 half periods each
	localparam int TOTAL_BYTES = 55;
	localparam int WATCHDOG_NS = TOTAL_BYTES * 9 * 2 * HALF_CLKS * 40 + 200000;

	typedef burst_mem_pkg::mem_write_s rec_q_t[$];
	typedef logic [7:0] byte_q_t[$];

	logic Clock;
	logic Reset;
	logic scl = 1'b1;
	logic sda_ctrl = 1'b1;
	logic sda_bus;
	logic sda_drive_low;
	logic wr_valid;
	logic credit_return = 1'b0;
	burst_mem_pkg::mem_write_s wr_out;

	integer seed = 86178;
	byte_q_t burst_data;
	rec_q_t expect_q;
	int pending_credits = 0;
	logic hold_credits = 1'b0;

	// open drain, target pulls low
	assign sda_bus = sda_ctrl & ~sda_drive_low;

	tb_clock_gen clk0
	(
		.Clock (Clock),
		.Reset (Reset)
	);

	i2c_burst_slave_top dut0
	(
		.Clock         (Clock),
		.Reset         (Reset),
		.scl           (scl),
		.sda           (sda_bus),
		.strap         (STRAP_VALUE),
		.sda_drive_low (sda_drive_low),
		.wr_valid      (wr_valid),
		.wr_out        (wr_out),
		.credit_return (credit_return)
	);

	////////////////////////////////////////
	// reference and compare
	////////////////////////////////////////

	// records at start address plus index, wrapping at 2048
	function automatic rec_q_t expected_records(
		input logic [burst_mem_pkg::ADDR_BITS-1:0] start_addr,
		input byte_q_t data,
		input int accepted);
		rec_q_t recs;
		burst_mem_pkg::mem_write_s rec;
		int sum;
		for (int i = 0; i < accepted; i++)
		begin
			sum = int'(start_addr) + i;
			rec.addr = sum[burst_mem_pkg::ADDR_BITS-1:0];
			rec.data = data[i];
			recs.push_back(rec);
		end
		return recs;
	endfunction

	function automatic logic [7:0] device_byte(input logic [3:0] prefix,
		input logic [i2c_bus_pkg::STRAP_BITS-1:0] pins, input logic rw);
		i2c_bus_pkg::i2c_byte_u b;
		b.dev.dev_addr = {prefix, pins};
		b.dev.rw = rw;
		return b.raw;
	endfunction

	task automatic check_ack(input logic got, input logic expected, input string what);
		i2c_bus_pkg::byte_phase_e ph;
		ph = dut0.deser0.phase;
		if (got !== expected)
		begin
			$display("** Error at %0t: %s ack %b, expected %b (phase %s)",
				$time, what, got, expected, ph.name());
			$display("Something failed");
			$fatal(1);
		end
	endtask

	task automatic check_record(input burst_mem_pkg::mem_write_s got,
		input burst_mem_pkg::mem_write_s expected);
		if (got !== expected)
		begin
			$display("** Error at %0t: record addr %0d data %02h, expected addr %0d data %02h",
				$time, got.addr, got.data, expected.addr, expected.data);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	initial
	begin
		forever
		begin
			@(posedge Clock);
			if (Reset && wr_valid)
			begin
				if (expect_q.size() != 0)
				begin
					check_record(wr_out, expect_q.pop_front());
					pending_credits++;
				end
				else
				begin
					$display("** Error at %0t: write record addr %0d data %02h not expected",
						$time, wr_out.addr, wr_out.data);
					$display("Something failed");
					$fatal(1);
				end
			end
		end
	end

	// memory sink, one credit back per record after a short delay
	initial
	begin : credit_sink
		int delay;
		forever
		begin
			@(posedge Clock);
			if (pending_credits > 0 && !hold_credits)
			begin
				delay = 1 + ($unsigned($random(seed)) % 6);
				repeat (delay - 1) @(posedge Clock);
				credit_return <= 1'b1;
				@(posedge Clock);
				credit_return <= 1'b0;
				pending_credits--;
			end
		end
	end

	////////////////////////////////////////
	// I2C controller
	////////////////////////////////////////

	task automatic wait_clocks(input int n);
		repeat (n) @(posedge Clock);
	endtask

	// also serves as repeated START from scl low
	task automatic start_cond();
		wait_clocks(HALF_CLKS / 2);
		sda_ctrl <= 1'b1;
		wait_clocks(HALF_CLKS / 2);
		scl <= 1'b1;
		wait_clocks(HALF_CLKS);
		sda_ctrl <= 1'b0;
		wait_clocks(HALF_CLKS);
		scl <= 1'b0;
	endtask

	task automatic stop_cond();
		wait_clocks(HALF_CLKS / 2);
		sda_ctrl <= 1'b0;
		wait_clocks(HALF_CLKS / 2);
		scl <= 1'b1;
		wait_clocks(HALF_CLKS);
		sda_ctrl <= 1'b1;
		wait_clocks(HALF_CLKS);
	endtask

	// msb first, then release sda for the ack bit
	task automatic send_byte(input logic [7:0] b, output logic ack);
		for (int i = 7; i >= 0; i--)
		begin
			wait_clocks(HALF_CLKS / 2);
			sda_ctrl <= b[i];
			wait_clocks(HALF_CLKS / 2);
			scl <= 1'b1;
			wait_clocks(HALF_CLKS);
			scl <= 1'b0;
		end
		wait_clocks(HALF_CLKS / 2);
		sda_ctrl <= 1'b1;
		wait_clocks(HALF_CLKS / 2);
		scl <= 1'b1;
		wait_clocks(HALF_CLKS - 1);
		ack = ~sda_bus;
		wait_clocks(1);
		scl <= 1'b0;
	endtask

	task automatic write_burst(input logic [burst_mem_pkg::ADDR_BITS-1:0] start_addr,
		input int accepted, input logic with_stop);
		rec_q_t recs;
		logic ack;
		recs = expected_records(start_addr, burst_data, accepted);
		foreach (recs[i])
		begin
			expect_q.push_back(recs[i]);
		end
		start_cond();
		send_byte(device_byte(i2c_bus_pkg::DEVICE_PREFIX, STRAP_VALUE, 1'b0), ack);
		check_ack(ack, 1'b1, "device address");
		send_byte(8'(start_addr >> 8), ack);
		check_ack(ack, 1'b1, "burst address high");
		send_byte(start_addr[7:0], ack);
		check_ack(ack, 1'b1, "burst address low");
		for (int i = 0; i < burst_data.size(); i++)
		begin
			send_byte(burst_data[i], ack);
			check_ack(ack, (i < accepted), "data byte");
		end
		if (with_stop)
		begin
			stop_cond();
		end
	endtask

	task automatic fill_data(input int n);
		burst_data.delete();
		repeat (n) burst_data.push_back(8'($random(seed)));
	endtask

	// all records seen and credits back home
	task automatic drain_records();
		while (expect_q.size() != 0 || pending_credits != 0)
		begin
			wait_clocks(1);
		end
		wait_clocks(20);
	endtask

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial
	begin
		logic ack;
		@(posedge Reset);
		wait_clocks(4);

		// plain burst at a random address
		fill_data(6);
		write_burst(11'($random(seed)), 6, 1'b1);
		drain_records();

		// other targets
		start_cond();
		send_byte(device_byte(4'b1011, STRAP_VALUE, 1'b0), ack);
		check_ack(ack, 1'b0, "foreign prefix");
		stop_cond();
		start_cond();
		send_byte(device_byte(i2c_bus_pkg::DEVICE_PREFIX, 3'b100, 1'b0), ack);
		check_ack(ack, 1'b0, "foreign strap");
		stop_cond();
		drain_records();

		// read request ignored, then a normal write
		start_cond();
		send_byte(device_byte(i2c_bus_pkg::DEVICE_PREFIX, STRAP_VALUE, 1'b1), ack);
		check_ack(ack, 1'b0, "read request");
		stop_cond();
		fill_data(2);
		write_burst(11'h155, 2, 1'b1);
		drain_records();

		// address wrap
		fill_data(4);
		write_burst(11'd2046, 4, 1'b1);
		drain_records();

		// back pressure with credits withheld
		hold_credits = 1'b1;
		fill_data(16);
		write_burst(11'($random(seed)), ACCEPT_LIMIT, 1'b1);
		wait_clocks(40);
		hold_credits = 1'b0;
		drain_records();

		// repeated START restarts the burst
		fill_data(3);
		write_burst(11'h0a0, 3, 1'b0);
		fill_data(3);
		write_burst(11'h3f0, 3, 1'b1);
		drain_records();

		$display("Everything OK");
		$finish;
	end

	initial
	begin : watchdog
		#(WATCHDOG_NS);
		$display("watchdog timeout: write records missing");
		$display("Something failed");
		$fatal(1);
	end

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen
(
	output logic Clock,
	output logic Reset
);

	// 40 ns period
	initial
	begin
		Clock = 1'b0;
		forever #20 Clock = ~Clock;
	end

	// reset held low for two rising edges
	initial
	begin
		Reset <= 1'b0;
		repeat (2) @(posedge Clock);
		Reset <= 1'b1;
	end

endmodule

/* hw/i2c_burst_slave_top.sv */
`timescale 1ns/1ps

module i2c_burst_slave_top
(
	input  logic                               Clock,
	input  logic                               Reset,
	input  logic                               scl,
	input  logic                               sda,
	input  logic [i2c_bus_pkg::STRAP_BITS-1:0] strap,
	output logic                               sda_drive_low,
	output logic                               wr_valid,
	output burst_mem_pkg::mem_write_s          wr_out,
	input  logic                               credit_return
);

	// sampler to deserializer
	logic sda_level;
	logic scl_rise;
	logic scl_fall;
	logic start_seen;
	logic stop_seen;

	// deserializer to queue
	logic                      push;
	burst_mem_pkg::mem_write_s push_data;
	logic                      full;

	i2c_line_sampler sampler0
	(
		.Clock      (Clock),
		.Reset      (Reset),
		.scl        (scl),
		.sda        (sda),
		.sda_level  (sda_level),
		.scl_rise   (scl_rise),
		.scl_fall   (scl_fall),
		.start_seen (start_seen),
		.stop_seen  (stop_seen)
	);

	i2c_deserializer deser0
	(
		.Clock         (Clock),
		.Reset         (Reset),
		.strap         (strap),
		.sda_level     (sda_level),
		.scl_rise      (scl_rise),
		.scl_fall      (scl_fall),
		.start_seen    (start_seen),
		.stop_seen     (stop_seen),
		.full          (full),
		.push          (push),
		.push_data     (push_data),
		.sda_drive_low (sda_drive_low)
	);

	burst_write_queue queue0
	(
		.Clock         (Clock),
		.Reset         (Reset),
		.push          (push),
		.push_data     (push_data),
		.full          (full),
		.wr_valid      (wr_valid),
		.wr_out        (wr_out),
		.credit_return (credit_return)
	);

endmodule

/* hw/burst_write_queue.sv */
`timescale 1ns/1ps

module burst_write_queue
(
	input  logic                      Clock,
	input  logic                      Reset,
	input  logic                      push,
	input  burst_mem_pkg::mem_write_s push_data,
	output logic                      full,
	output logic                      wr_valid,
	output burst_mem_pkg::mem_write_s wr_out,
	input  logic                      credit_return
);

	burst_mem_pkg::mem_write_s mem [burst_mem_pkg::QUEUE_DEPTH];

	logic [burst_mem_pkg::QUEUE_PTR_BITS-1:0] wr_ptr;
	logic [burst_mem_pkg::QUEUE_PTR_BITS-1:0] rd_ptr;
	logic [burst_mem_pkg::QUEUE_CNT_BITS-1:0] count;
	logic [burst_mem_pkg::CREDIT_BITS-1:0]    credits;

	logic wr_en;
	logic send;

	assign full  = (count == burst_mem_pkg::QUEUE_FULL);
	assign wr_en = push && !full;

	// one record leaves per cycle while credits last
	assign send     = (count != '0) && (credits != '0);
	assign wr_valid = send;
	assign wr_out   = mem[rd_ptr];

	always_ff @(posedge Clock)
	begin
		if (wr_en)
		begin
			mem[wr_ptr] <= push_data;
		end
	end

	////////////////////////////////////////
	// pointers and fill count
	////////////////////////////////////////

	always_ff @(posedge Clock or negedge Reset)
	begin
		if (!Reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (wr_en)
			begin
				wr_ptr <= (wr_ptr == burst_mem_pkg::QUEUE_LAST) ? '0 : wr_ptr + 1'b1;
			end
			if (send)
			begin
				rd_ptr <= (rd_ptr == burst_mem_pkg::QUEUE_LAST) ? '0 : rd_ptr + 1'b1;
			end
			case ({wr_en, send})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	////////////////////////////////////////
	// credit counter
	////////////////////////////////////////

	always_ff @(posedge Clock or negedge Reset)
	begin
		if (!Reset)
		begin
			credits <= burst_mem_pkg::CREDIT_MAX;
		end
		else
		begin
			// send and return in one cycle cancel out
			case ({send, credit_return})
				2'b10: credits <= credits - 1'b1;
				2'b01:
				begin
					if (credits != burst_mem_pkg::CREDIT_MAX)
					begin
						credits <= credits + 1'b1;
					end
				end
				default: credits <= credits;
			endcase
		end
	end

	a_credit_bound: assert property (
		@(posedge Clock) disable iff (!Reset)
		credits <= burst_mem_pkg::CREDIT_MAX
	);

	// with credits spent nothing leaves until one comes back
	a_valid_needs_credit: assert property (
		@(posedge Clock) disable iff (!Reset)
		(credits == '0) && !credit_return |=> !wr_valid
	);

endmodule

/* hw/i2c_deserializer.sv */
`timescale 1ns/1ps

module i2c_deserializer
(
	input  logic                                Clock,
	input  logic                                Reset,
	input  logic [i2c_bus_pkg::STRAP_BITS-1:0]  strap,
	input  logic                                sda_level,
	input  logic                                scl_rise,
	input  logic                                scl_fall,
	input  logic                                start_seen,
	input  logic                                stop_seen,
	input  logic                                full,
	output logic                                push,
	output burst_mem_pkg::mem_write_s           push_data,
	output logic                                sda_drive_low
);

	i2c_bus_pkg::byte_phase_e phase;
	i2c_bus_pkg::byte_phase_e phase_next;

	// bits shifted so far where 8 means byte complete
	logic [3:0] bit_cnt;

	// set during the ninth clock of a byte
	logic ack_slot;

	i2c_bus_pkg::i2c_byte_u shift;
	logic [burst_mem_pkg::ADDR_BITS-1:0] burst_addr;

	logic shift_en;
	logic byte_done;
	logic dev_match;
	logic ack_now;

	////////////////////////////////////////
	// byte framing
	////////////////////////////////////////

	assign shift_en = scl_rise && (phase != i2c_bus_pkg::PH_IGNORE) && (bit_cnt != 4'd8);

	// falling scl right after bit 8 is the ack decision point
	assign byte_done = scl_fall && (bit_cnt == 4'd8) && !ack_slot;

	always_ff @(posedge Clock)
	begin
		if (shift_en)
		begin
			// msb first
			shift.raw <= {shift.raw[6:0], sda_level};
		end
	end

	////////////////////////////////////////
	// byte decode
	////////////////////////////////////////

	assign dev_match = (shift.dev.dev_addr == {i2c_bus_pkg::DEVICE_PREFIX, strap})
		&& !shift.dev.rw;

	always_comb
	begin
		ack_now    = 1'b0;
		phase_next = phase;
		case (phase)
			i2c_bus_pkg::PH_DEVICE:
			begin
				// reads and other targets are left alone
				if (dev_match)
				begin
					ack_now    = 1'b1;
					phase_next = i2c_bus_pkg::PH_ADDR_HI;
				end
				else
				begin
					phase_next = i2c_bus_pkg::PH_IGNORE;
				end
			end
			i2c_bus_pkg::PH_ADDR_HI:
			begin
				ack_now    = 1'b1;
				phase_next = i2c_bus_pkg::PH_ADDR_LO;
			end
			i2c_bus_pkg::PH_ADDR_LO:
			begin
				ack_now    = 1'b1;
				phase_next = i2c_bus_pkg::PH_DATA;
			end
			i2c_bus_pkg::PH_DATA:
			begin
				// nack when the queue cannot take the record
				ack_now = !full;
			end
			default:
			begin
				ack_now = 1'b0;
			end
		endcase
	end

	// a data byte is pushed exactly when it is acked
	assign push = byte_done && (phase == i2c_bus_pkg::PH_DATA) && ack_now;

	assign push_data.addr = burst_addr;
	assign push_data.data = shift.raw;

	////////////////////////////////////////
	// phase and ack control
	////////////////////////////////////////

	always_ff @(posedge Clock or negedge Reset)
	begin
		if (!Reset)
		begin
			phase         <= i2c_bus_pkg::PH_IGNORE;
			bit_cnt       <= 4'd0;
			ack_slot      <= 1'b0;
			sda_drive_low <= 1'b0;
		end
		else if (start_seen)
		begin
			// repeated START lands here too
			phase         <= i2c_bus_pkg::PH_DEVICE;
			bit_cnt       <= 4'd0;
			ack_slot      <= 1'b0;
			sda_drive_low <= 1'b0;
		end
		else if (stop_seen)
		begin
			phase         <= i2c_bus_pkg::PH_IGNORE;
			bit_cnt       <= 4'd0;
			ack_slot      <= 1'b0;
			sda_drive_low <= 1'b0;
		end
		else if (shift_en)
		begin
			bit_cnt <= bit_cnt + 1'b1;
		end
		else if (byte_done)
		begin
			ack_slot      <= 1'b1;
			sda_drive_low <= ack_now;
			phase         <= phase_next;
		end
		else if (scl_fall && ack_slot)
		begin
			// end of ninth clock releases sda
			ack_slot      <= 1'b0;
			sda_drive_low <= 1'b0;
			bit_cnt       <= 4'd0;
		end
	end

	// burst address load and post increment
	always_ff @(posedge Clock)
	begin
		if (byte_done && (phase == i2c_bus_pkg::PH_ADDR_HI))
		begin
			burst_addr[burst_mem_pkg::ADDR_BITS-1:8] <=
				shift.raw[burst_mem_pkg::ADDR_HI_BITS-1:0];
		end
		else if (byte_done && (phase == i2c_bus_pkg::PH_ADDR_LO))
		begin
			burst_addr[7:0] <= shift.raw;
		end
		else if (push)
		begin
			// wraps at the top of the burst space
			burst_addr <= burst_addr + 1'b1;
		end
	end

	a_push_not_full: assert property (
		@(posedge Clock) disable iff (!Reset)
		push |-> !full
	);

	a_no_ack_when_ignoring: assert property (
		@(posedge Clock) disable iff (!Reset)
		sda_drive_low |-> (phase != i2c_bus_pkg::PH_IGNORE)
	);

endmodule

/* hw/i2c_line_sampler.sv */
`timescale 1ns/1ps

module i2c_line_sampler
(
	input  logic Clock,
	input  logic Reset,
	input  logic scl,
	input  logic sda,
	output logic sda_level,
	output logic scl_rise,
	output logic scl_fall,
	output logic start_seen,
	output logic stop_seen
);

	// two flop synchronizers with bit 1 as the safe one
	logic [1:0] scl_sync;
	logic [1:0] sda_sync;

	// delayed copies for edge compare
	logic scl_prev;
	logic sda_prev;

	// scl high in both samples around an sda edge
	logic scl_high;

	assign scl_high = scl_sync[1] & scl_prev;

	////////////////////////////////////////
	// synchronize and compare
	////////////////////////////////////////

	always_ff @(posedge Clock or negedge Reset)
	begin
		if (!Reset)
		begin
			// idle bus is high on both lines
			scl_sync   <= 2'b11;
			sda_sync   <= 2'b11;
			scl_prev   <= 1'b1;
			sda_prev   <= 1'b1;
			scl_rise   <= 1'b0;
			scl_fall   <= 1'b0;
			start_seen <= 1'b0;
			stop_seen  <= 1'b0;
		end
		else
		begin
			scl_sync <= {scl_sync[0], scl};
			sda_sync <= {sda_sync[0], sda};
			scl_prev <= scl_sync[1];
			sda_prev <= sda_sync[1];

			scl_rise <= scl_sync[1] & ~scl_prev;
			scl_fall <= ~scl_sync[1] & scl_prev;

			// sda falling with scl high is START and rising is STOP
			start_seen <= ~sda_sync[1] & sda_prev & scl_high;
			stop_seen  <= sda_sync[1] & ~sda_prev & scl_high;
		end
	end

	// level lines up with the registered pulses
	assign sda_level = sda_prev;

	// a one cycle sda glitch with scl high would give back to back conditions
	a_start_stop_excl: assert property (
		@(posedge Clock) disable iff (!Reset)
		(start_seen || stop_seen) |=> !(start_seen || stop_seen)
	);

endmodule

/* hw/burst_mem_pkg.sv */
package burst_mem_pkg;

	////////////////////////////////////////
	// burst address and write record
	////////////////////////////////////////

	localparam int ADDR_BITS = 11;

	// bits of the first address byte that reach the burst address
	localparam int ADDR_HI_BITS = ADDR_BITS - 8;

	typedef struct packed
	{
		logic [ADDR_BITS-1:0] addr;
		logic [7:0]           data;
	} mem_write_s;

	////////////////////////////////////////
	// write queue and credits
	////////////////////////////////////////

	localparam int QUEUE_DEPTH = 8;
	localparam int QUEUE_PTR_BITS = $clog2(QUEUE_DEPTH);
	localparam int QUEUE_CNT_BITS = $clog2(QUEUE_DEPTH + 1);
	localparam logic [QUEUE_PTR_BITS-1:0] QUEUE_LAST = QUEUE_PTR_BITS'(QUEUE_DEPTH - 1);
	localparam logic [QUEUE_CNT_BITS-1:0] QUEUE_FULL = QUEUE_CNT_BITS'(QUEUE_DEPTH);

	// credits granted by the memory after reset
	localparam int MEM_CREDITS = 4;
	localparam int CREDIT_BITS = $clog2(MEM_CREDITS + 1);
	localparam logic [CREDIT_BITS-1:0] CREDIT_MAX = CREDIT_BITS'(MEM_CREDITS);

endpackage

/* hw/i2c_bus_pkg.sv */
package i2c_bus_pkg;

	////////////////////////////////////////
	// device address
	////////////////////////////////////////

	// fixed upper nibble of the 7-bit target address
	localparam logic [3:0] DEVICE_PREFIX = 4'b1010;

	// low address bits come from board pins
	localparam int STRAP_BITS = 3;

	////////////////////////////////////////
	// byte phases
	////////////////////////////////////////

	// which byte of the transfer is being shifted in
	typedef enum logic [2:0]
	{
		PH_DEVICE  = 3'd0,
		PH_ADDR_HI = 3'd1,
		PH_ADDR_LO = 3'd2,
		PH_DATA    = 3'd3,
		PH_IGNORE  = 3'd4
	} byte_phase_e;

	////////////////////////////////////////
	// received byte views
	////////////////////////////////////////

	// first byte after START: address in bits 7..1, direction in bit 0
	typedef struct packed
	{
		logic [6:0] dev_addr;
		logic       rw;
	} i2c_dev_byte_s;

	// the shift register is read as either view depending on phase
	typedef union packed
	{
		logic [7:0]    raw;
		i2c_dev_byte_s dev;
	} i2c_byte_u;

endpackage
